/* run_sim.sh */
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and fails unless the pass line appears.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_uart_parity -f uart_parity.f -o sim_uart_parity \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_uart_parity 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb/tb_clock_gen.sv */
// Free-running testbench clock with an 8 ns period, instantiated by the UART testbench.
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // half period of 4 ns.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* tb/tb_uart_parity.sv */
// Testbench for the parity UART: loopback traffic, injected bad frames, reference check, report.
module tb_uart_parity;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS  = uart_pkg::CLKS_PER_BIT;
    localparam int PAR_MID   = 9 * uart_pkg::CLKS_PER_BIT + uart_pkg::CLKS_PER_BIT / 2;
    localparam int N_FRAMES  = 2 * 32 + 8 + 3 * 8 + 1;
    localparam int WDOG_CYCLES = N_FRAMES * 11 * uart_pkg::CLKS_PER_BIT * 2 + 1000;

    logic                 clk;
    logic                 rst_n;
    uart_pkg::uart_cfg_t  cfg;
    uart_pkg::uart_byte_t tx_data;
    logic                 tx_start;
    logic                 rxd;
    logic                 txd;
    logic                 tx_busy;
    logic                 rx_valid;
    uart_pkg::rx_result_t rx_result;

    logic                 use_inject;
    logic                 inj_line;
    logic [31:0]          lfsr;
    uart_pkg::rx_result_t exp_q[$];

    int rx_mismatches = 0;
    int rx_failures = 0;
    int frames_checked = 0;
    int tx_mismatches = 0;
    int tx_failures = 0;

    tb_clock_gen clk_gen (.clk(clk));

    uart_parity_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .rxd       (rxd),
        .txd       (txd),
        .tx_busy   (tx_busy),
        .rx_valid  (rx_valid),
        .rx_result (rx_result)
    );

    // loopback unless a hand-built frame is being injected.
    assign rxd = use_inject ? inj_line : txd;

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic uart_pkg::uart_byte_t random_byte();
        uart_pkg::uart_byte_t b;
        for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
            b[i] = lfsr_bit();
        end
        return b;
    endfunction

    function automatic uart_pkg::uart_cfg_t make_cfg(input logic en, input logic typ);
        uart_pkg::uart_cfg_t c;
        c.parity_en   = en;
        c.parity_type = typ;
        return c;
    endfunction

    // xor of all data bits, inverted for odd parity.
    function automatic logic ref_parity(input uart_pkg::uart_byte_t data, input logic typ);
        logic p;
        p = typ;
        for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
            p = p ^ data[i];
        end
        return p;
    endfunction

    function automatic uart_pkg::rx_result_t expected_result(
        input uart_pkg::uart_byte_t data,
        input uart_pkg::uart_cfg_t  c,
        input logic                 sent_parity,
        input logic                 sent_stop
    );
        uart_pkg::rx_result_t r;
        r.data        = data;
        r.parity_err  = c.parity_en && (sent_parity != ref_parity(data, c.parity_type));
        r.framing_err = !sent_stop;
        return r;
    endfunction

    always @(negedge clk) begin
        uart_pkg::rx_result_t want;
        if (rst_n && rx_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected rx_valid at time %0t with no frame outstanding (data %02h)",
                         $time, rx_result.data);
                rx_failures++;
            end else begin
                want = exp_q.pop_front();
                frames_checked++;
                if (rx_result !== want) begin
                    $display("Mismatch at time %0t: got %02h/%0b/%0b, expected %02h/%0b/%0b",
                             $time, rx_result.data, rx_result.parity_err,
                             rx_result.framing_err, want.data, want.parity_err,
                             want.framing_err);
                    rx_mismatches++;
                end
            end
        end
    end

    task automatic wait_rx_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 4 * BIT_CLKS) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("No rx_valid arrived for an expected frame by time %0t", $time);
            tx_failures++;
            exp_q.delete();
        end
    endtask

    // sends one byte through the transmitter, optionally pulsing a second start mid-frame.
    task automatic transmit_byte(
        input uart_pkg::uart_byte_t data,
        input uart_pkg::uart_cfg_t  c,
        input logic                 overlap,
        input uart_pkg::uart_byte_t second
    );
        int   n;
        int   expected_len;
        logic par_seen;
        expected_len = (c.parity_en ? 11 : 10) * BIT_CLKS;
        par_seen = 1'b0;
        @(posedge clk);
        cfg      <= c;
        tx_data  <= data;
        tx_start <= 1'b1;
        exp_q.push_back(expected_result(data, c, ref_parity(data, c.parity_type), 1'b1));
        @(posedge clk);
        tx_start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (tx_busy && n < 12 * BIT_CLKS) begin
            n++;
            if (c.parity_en && n == PAR_MID) begin
                par_seen = txd;
            end
            if (overlap && n == 3 * BIT_CLKS) begin
                @(posedge clk);
                tx_data  <= second;
                tx_start <= 1'b1;
            end
            if (overlap && n == 3 * BIT_CLKS + 1) begin
                @(posedge clk);
                tx_start <= 1'b0;
            end
            @(negedge clk);
        end
        if (n != expected_len) begin
            $display("Mismatch at time %0t: tx_busy lasted %0d cycles, expected %0d",
                     $time, n, expected_len);
            tx_mismatches++;
        end
        if (c.parity_en && par_seen !== ref_parity(data, c.parity_type)) begin
            $display("Mismatch at time %0t: parity bit on txd %0b for byte %02h, expected %0b",
                     $time, par_seen, data, ref_parity(data, c.parity_type));
            tx_mismatches++;
        end
        wait_rx_drain();
    endtask

    task automatic hold_line(input logic level);
        @(posedge clk);
        inj_line <= level;
        repeat (BIT_CLKS - 1) @(posedge clk);
    endtask

    // builds a frame on the receive line with a chosen parity bit and stop bit.
    task automatic send_frame(
        input uart_pkg::uart_byte_t data,
        input uart_pkg::uart_cfg_t  c,
        input logic                 sent_parity,
        input logic                 sent_stop
    );
        @(posedge clk);
        cfg <= c;
        exp_q.push_back(expected_result(data, c, sent_parity, sent_stop));
        hold_line(1'b0);
        for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
            hold_line(data[i]);
        end
        if (c.parity_en) begin
            hold_line(sent_parity);
        end
        hold_line(sent_stop);
        hold_line(1'b1);
        hold_line(1'b1);
        wait_rx_drain();
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the test finished", WDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        uart_pkg::uart_byte_t b;
        uart_pkg::uart_cfg_t  c;
        logic                 late_busy;
        rst_n      = 1'b0;
        cfg        = make_cfg(1'b0, 1'b0);
        tx_data    = '0;
        tx_start   = 1'b0;
        use_inject = 1'b0;
        inj_line   = 1'b1;
        lfsr       = 32'h8f0b9e00;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // loopback, even then odd parity, then parity off.
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < 32; i++) begin
                transmit_byte(random_byte(), make_cfg(1'b1, t[0]), 1'b0, 8'h00);
            end
        end
        for (int i = 0; i < 8; i++) begin
            transmit_byte(random_byte(), make_cfg(1'b0, i[0]), 1'b0, 8'h00);
        end

        @(posedge clk);
        use_inject <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            send_frame(random_byte(), make_cfg(1'b0, i[0]), lfsr_bit(), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            c = make_cfg(1'b1, i[0]);
            b = random_byte();
            send_frame(b, c, !ref_parity(b, c.parity_type), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            c = make_cfg(i[1], i[0]);
            b = random_byte();
            send_frame(b, c, ref_parity(b, c.parity_type), 1'b0);
        end
        @(posedge clk);
        use_inject <= 1'b0;

        // second start during a busy frame must be dropped, now or after the first frame.
        transmit_byte(random_byte(), make_cfg(1'b1, 1'b0), 1'b1, random_byte());
        late_busy = 1'b0;
        repeat (2 * 11 * BIT_CLKS) begin
            @(negedge clk);
            late_busy = late_busy | tx_busy;
        end
        if (late_busy) begin
            $display("Transmitter started a second frame from a start pulsed while busy");
            tx_failures++;
        end

        $display("errors: %0d rx mismatches, %0d tx mismatches, %0d other failures, %0d frames",
                 rx_mismatches, tx_mismatches, rx_failures + tx_failures, frames_checked);
        if (rx_mismatches + tx_mismatches + rx_failures + tx_failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/uart_parity_checker.sv */
// Concurrent protocol assertions for the parity UART, bound to uart_parity_top below.
module uart_parity_checker (
    input logic clk,
    input logic rst_n,
    input logic tx_start,
    input logic tx_busy,
    input logic txd,
    input logic rx_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // an idle transmitter holds the line at the stop level.
    property idle_line_high;
        @(posedge clk) disable iff (!rst_n) !tx_busy |-> txd;
    endproperty

    property rx_valid_single;
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid;
    endproperty

    // accepted start shows up as busy on the next cycle.
    property busy_after_start;
        @(posedge clk) disable iff (!rst_n) (tx_start && !tx_busy) |=> tx_busy;
    endproperty

    assert property (idle_line_high)
        else $error("txd is low while the transmitter is idle");
    assert property (rx_valid_single)
        else $error("rx_valid stayed high for two consecutive cycles");
    assert property (busy_after_start)
        else $error("tx_busy did not rise after an accepted tx_start");

endmodule

bind uart_parity_top uart_parity_checker chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .txd      (txd),
    .rx_valid (rx_valid)
);

/* uart_parity.f */
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_parity_unit.sv
verilog/uart_parity_top.sv
tb/tb_clock_gen.sv
tb/uart_parity_checker.sv
tb/tb_uart_parity.sv

/* verilog/uart_parity_top.sv */
// Top level of the parity UART, joining transmitter, receiver and the shared parity unit.
module uart_parity_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_cfg_t  cfg,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                 tx_start,
    input  logic                 rxd,
    output logic                 txd,
    output logic                 tx_busy,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result
);

    logic                 tx_parity_req;
    uart_pkg::uart_byte_t tx_parity_data;
    logic                 tx_parity;
    logic                 frame_valid;
    uart_pkg::rx_frame_t  rx_frame;
    logic                 rx_parity_type;

    uart_tx u_tx (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .tx_data        (tx_data),
        .tx_start       (tx_start),
        .tx_parity      (tx_parity),
        .tx_parity_req  (tx_parity_req),
        .tx_parity_data (tx_parity_data),
        .txd            (txd),
        .tx_busy        (tx_busy)
    );

    // the request is made in the accept cycle, so the live type is the frame's type.
    uart_parity_unit u_parity (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_parity_type (cfg.parity_type),
        .tx_parity_req   (tx_parity_req),
        .tx_parity_data  (tx_parity_data),
        .tx_parity       (tx_parity),
        .frame_valid     (frame_valid),
        .rx_frame        (rx_frame),
        .rx_parity_type  (rx_parity_type),
        .rx_valid        (rx_valid),
        .rx_result       (rx_result)
    );

    uart_rx u_rx (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .rxd            (rxd),
        .frame_valid    (frame_valid),
        .rx_frame       (rx_frame),
        .rx_parity_type (rx_parity_type)
    );

endmodule

/* verilog/uart_parity_unit.sv */
// Parity generation for the transmitter and parity/stop checking for received frames.
module uart_parity_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_parity_type,
    input  logic                 tx_parity_req,
    input  uart_pkg::uart_byte_t tx_parity_data,
    output logic                 tx_parity,
    input  logic                 frame_valid,
    input  uart_pkg::rx_frame_t  rx_frame,
    input  logic                 rx_parity_type,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result
);

    // even parity for type 0, odd parity for type 1.
    function automatic logic parity_of(
        input uart_pkg::uart_byte_t data,
        input logic                 parity_type
    );
        return (^data) ^ parity_type;
    endfunction

    logic rx_parity_bad;

    assign rx_parity_bad = rx_frame.parity_present &&
                           (parity_of(rx_frame.data, rx_parity_type) != rx_frame.parity_bit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_parity <= 1'b0;
        end else if (tx_parity_req) begin
            tx_parity <= parity_of(tx_parity_data, cfg_parity_type);
        end
    end

    // a new frame simply overwrites the previous result.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            rx_result <= '0;
        end else begin
            rx_valid <= frame_valid;
            if (frame_valid) begin
                rx_result.data        <= rx_frame.data;
                rx_result.parity_err  <= rx_parity_bad;
                rx_result.framing_err <= !rx_frame.stop_ok;
            end
        end
    end

endmodule

/* verilog/uart_pkg.sv */
// Shared UART constants, vector types, FSM encodings and frame structs for the RTL and testbench.
package uart_pkg;

    // bit timing.
    localparam int CLKS_PER_BIT = 16;
    localparam int DATA_BITS    = 8;

    typedef logic [7:0] uart_byte_t;
    typedef logic [3:0] bit_cnt_t;
    typedef logic [4:0] baud_cnt_t;

    // last count of a full bit period and of half a bit period.
    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
    localparam bit_cnt_t  DATA_LAST = bit_cnt_t'(DATA_BITS - 1);

    typedef struct packed {
        logic parity_en;
        logic parity_type;
    } uart_cfg_t;

    // one received frame, as sampled on the line.
    typedef struct packed {
        uart_byte_t data;
        logic       parity_bit;
        logic       parity_present;
        logic       stop_ok;
    } rx_frame_t;

    typedef struct packed {
        uart_byte_t data;
        logic       parity_err;
        logic       framing_err;
    } rx_result_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage

/* verilog/uart_rx.sv */
// UART receiver with input synchronizer and mid-bit sampling, emitting one frame struct per frame.
module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_cfg_t  cfg,
    input  logic                 rxd,
    output logic                 frame_valid,
    output uart_pkg::rx_frame_t  rx_frame,
    output logic                 rx_parity_type
);

    uart_pkg::rx_state_t  state;
    uart_pkg::baud_cnt_t  baud_cnt;
    uart_pkg::bit_cnt_t   bit_cnt;
    uart_pkg::uart_cfg_t  cfg_q;
    uart_pkg::uart_byte_t data_q;

    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;
    logic parity_q;
    logic fall;
    logic bit_end;

    // two-flop synchronizer, plus one more stage for edge detection.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall    = rxd_prev && !rxd_sync;
    assign bit_end = (baud_cnt == uart_pkg::BIT_LAST);

    // payload sampling at the middle of each data and parity bit.
    always_ff @(posedge clk) begin
        if (bit_end && (state == uart_pkg::RX_DATA)) begin
            data_q <= {rxd_sync, data_q[7:1]};
        end
        if (bit_end && (state == uart_pkg::RX_PARITY)) begin
            parity_q <= rxd_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_pkg::RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            cfg_q    <= '0;
        end else begin
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (fall) begin
                        state    <= uart_pkg::RX_START;
                        baud_cnt <= '0;
                        cfg_q    <= cfg;
                    end
                end
                uart_pkg::RX_START: begin
                    if (baud_cnt == uart_pkg::HALF_LAST) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // glitch if the line went high again before mid-bit.
                        state    <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        if (bit_cnt == uart_pkg::DATA_LAST) begin
                            state <= cfg_q.parity_en ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_PARITY: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= uart_pkg::RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= uart_pkg::RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // frame is complete at the stop-bit sample.
    assign frame_valid = bit_end && (state == uart_pkg::RX_STOP);

    assign rx_frame.data           = data_q;
    assign rx_frame.parity_bit     = parity_q;
    assign rx_frame.parity_present = cfg_q.parity_en;
    assign rx_frame.stop_ok        = rxd_sync;

    assign rx_parity_type = cfg_q.parity_type;

endmodule

/* verilog/uart_tx.sv */
// UART transmitter that serializes one byte per accepted tx_start, with optional parity bit.
module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_cfg_t  cfg,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                 tx_start,
    input  logic                 tx_parity,
    output logic                 tx_parity_req,
    output uart_pkg::uart_byte_t tx_parity_data,
    output logic                 txd,
    output logic                 tx_busy
);

    uart_pkg::tx_state_t  state;
    uart_pkg::baud_cnt_t  baud_cnt;
    uart_pkg::bit_cnt_t   bit_cnt;
    uart_pkg::uart_cfg_t  cfg_q;
    uart_pkg::uart_byte_t shift_q;

    logic accept;
    logic bit_end;
    logic shift_en;

    // a new frame is only taken while the line is idle.
    assign accept   = tx_start && (state == uart_pkg::TX_IDLE);
    assign bit_end  = (baud_cnt == uart_pkg::BIT_LAST);
    assign shift_en = bit_end &&
                      ((state == uart_pkg::TX_START) || (state == uart_pkg::TX_DATA));

    // parity is requested at accept time, so the unit sees the same byte and type.
    assign tx_parity_req  = accept;
    assign tx_parity_data = tx_data;

    assign tx_busy = (state != uart_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= tx_data;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            cfg_q    <= '0;
            txd      <= 1'b1;
        end else begin
            if (state != uart_pkg::TX_IDLE) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end

            case (state)
                uart_pkg::TX_IDLE: begin
                    if (accept) begin
                        state    <= uart_pkg::TX_START;
                        cfg_q    <= cfg;
                        baud_cnt <= '0;
                        txd      <= 1'b0;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_cnt <= '0;
                        txd     <= shift_q[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == uart_pkg::DATA_LAST) begin
                            if (cfg_q.parity_en) begin
                                state <= uart_pkg::TX_PARITY;
                                txd   <= tx_parity;
                            end else begin
                                state <= uart_pkg::TX_STOP;
                                txd   <= 1'b1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shift_q[0];
                        end
                    end
                end
                uart_pkg::TX_PARITY: begin
                    if (bit_end) begin
                        state <= uart_pkg::TX_STOP;
                        txd   <= 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    // line stays high into idle.
                    if (bit_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

endmodule
